/* Bender.yml */
package:
  name: cdc_fifo

sources:
  - common/fifo_pkg.sv
  - rtl/gray_sync.sv
  - fifo_logic/fifo_wr_ctrl.sv
  - fifo_logic/fifo_rd_ctrl.sv
  - fifo_logic/fifo_logic.sv
  - rtl/fifo_mem.sv
  - rtl/cdc_fifo.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/cdc_fifo_tb.sv

/* cdc_fifo.f */
common/fifo_pkg.sv
rtl/gray_sync.sv
fifo_logic/fifo_wr_ctrl.sv
fifo_logic/fifo_rd_ctrl.sv
fifo_logic/fifo_logic.sv
rtl/fifo_mem.sv
rtl/cdc_fifo.sv
tb/tb_clock_gen.sv
tb/cdc_fifo_tb.sv

/* common/fifo_pkg.sv */
/* Shared types and sizes for the dual-clock FIFO.
   FIFO_DEPTH must be a power of two and at least 4. */
package fifo_pkg;

  localparam int DATA_W      = 8;
  localparam int FIFO_DEPTH  = 16;
  localparam int ADDR_W      = $clog2(FIFO_DEPTH);
  // One extra wrap bit tells a full buffer from an empty one.
  localparam int PTR_W       = ADDR_W + 1;
  localparam int SYNC_STAGES = 2;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [PTR_W-1:0]  ptr_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } mem_wr_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
  } mem_rd_t;

  // Binary to reflected Gray code, so that only one bit changes per step.
  function automatic ptr_t bin2gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

endpackage

/* fifo_logic/fifo_logic.sv */
/* Pointer logic of the dual-clock FIFO, everything apart from storage.
   wrstn and rrstn must be synchronized to their clocks outside this block. */
`timescale 1ns/1ps

module fifo_logic
  import fifo_pkg::*;
(
  input  logic    wclk,
  input  logic    wrstn,
  input  logic    rclk,
  input  logic    rrstn,
  input  logic    en,
  input  logic    din_valid,
  input  data_t   din,
  output logic    wready,
  output mem_wr_t mem_wr,
  output mem_rd_t mem_rd,
  output logic    dout_valid
);

  ptr_t wptr_gray;
  ptr_t wptr_gray_sync;
  ptr_t rptr_gray;
  ptr_t rptr_gray_sync;

  fifo_wr_ctrl u_wr_ctrl (
    .wclk           (wclk),
    .wrstn          (wrstn),
    .din_valid      (din_valid),
    .din            (din),
    .rptr_gray_sync (rptr_gray_sync),
    .wready         (wready),
    .wptr_gray      (wptr_gray),
    .mem_wr         (mem_wr)
  );

  // Write pointer into the read domain.
  gray_sync #(.STAGES(SYNC_STAGES)) u_sync_w2r (
    .clk  (rclk),
    .rstn (rrstn),
    .d    (wptr_gray),
    .q    (wptr_gray_sync)
  );

  // Read pointer into the write domain.
  gray_sync #(.STAGES(SYNC_STAGES)) u_sync_r2w (
    .clk  (wclk),
    .rstn (wrstn),
    .d    (rptr_gray),
    .q    (rptr_gray_sync)
  );

  fifo_rd_ctrl u_rd_ctrl (
    .rclk           (rclk),
    .rrstn          (rrstn),
    .en             (en),
    .wptr_gray_sync (wptr_gray_sync),
    .rptr_gray      (rptr_gray),
    .mem_rd         (mem_rd),
    .dout_valid     (dout_valid)
  );

endmodule

/* fifo_logic/fifo_rd_ctrl.sv */
/* Read side of the dual-clock FIFO, all in the rclk domain.
   Reads run whenever en is high and data is present; there is no back-pressure. */
`timescale 1ns/1ps

module fifo_rd_ctrl
  import fifo_pkg::*;
(
  input  logic    rclk,
  input  logic    rrstn,
  input  logic    en,
  input  ptr_t    wptr_gray_sync,
  output ptr_t    rptr_gray,
  output mem_rd_t mem_rd,
  output logic    dout_valid
);

  ptr_t rptr_bin;
  ptr_t rptr_bin_next;
  ptr_t rptr_gray_next;
  logic renable;
  logic empty;

  // The pointer moves at the same edge the memory performs the read.
  assign rptr_bin_next  = rptr_bin + ptr_t'(renable);
  assign rptr_gray_next = bin2gray(rptr_bin_next);

  // Empty looks at the pointer after any read already under way.
  // Otherwise a single stored word could be read twice.
  assign empty = (rptr_gray_next == wptr_gray_sync);

  always_ff @(posedge rclk, negedge rrstn) begin
    if (!rrstn) begin
      rptr_bin  <= '0;
      rptr_gray <= '0;
    end else begin
      rptr_bin  <= rptr_bin_next;
      rptr_gray <= rptr_gray_next;
    end
  end

  // dout_valid trails renable by one cycle, in step with the memory output register.
  always_ff @(posedge rclk, negedge rrstn) begin
    if (!rrstn) begin
      renable    <= 1'b0;
      dout_valid <= 1'b0;
    end else begin
      renable    <= en & ~empty;
      dout_valid <= renable;
    end
  end

  always_comb begin
    mem_rd.en   = renable;
    mem_rd.addr = rptr_bin[ADDR_W-1:0];
  end

endmodule

/* fifo_logic/fifo_wr_ctrl.sv */
/* Write side of the dual-clock FIFO, all in the wclk domain.
   Full is pessimistic: it clears only after a read pointer update has been synchronized. */
`timescale 1ns/1ps

module fifo_wr_ctrl
  import fifo_pkg::*;
(
  input  logic    wclk,
  input  logic    wrstn,
  input  logic    din_valid,
  input  data_t   din,
  input  ptr_t    rptr_gray_sync,
  output logic    wready,
  output ptr_t    wptr_gray,
  output mem_wr_t mem_wr
);

  ptr_t wptr_bin;
  ptr_t wptr_bin_next;
  logic full;
  logic accept;

  // The buffer is full when the write pointer is one lap ahead of the read pointer.
  // In Gray code that means the top two bits differ and the rest match.
  assign full = (wptr_gray == {~rptr_gray_sync[PTR_W-1 -: 2], rptr_gray_sync[PTR_W-3:0]});

  assign wready = ~full;
  assign accept = din_valid & wready;

  assign wptr_bin_next = wptr_bin + ptr_t'(accept);

  always_ff @(posedge wclk, negedge wrstn) begin
    if (!wrstn) begin
      wptr_bin  <= '0;
      wptr_gray <= '0;
    end else begin
      wptr_bin  <= wptr_bin_next;
      wptr_gray <= bin2gray(wptr_bin_next);
    end
  end

  always_comb begin
    mem_wr.en   = accept;
    mem_wr.addr = wptr_bin[ADDR_W-1:0];
    mem_wr.data = din;
  end

endmodule

/* rtl/cdc_fifo.sv */
/* Dual-clock FIFO top level. Writes on wclk with din_valid and wready, reads on rclk with en.
   Both resets are asynchronous and must be released in step with their own clocks. */
`timescale 1ns/1ps

module cdc_fifo
  import fifo_pkg::*;
(
  input  logic  wclk,
  input  logic  wrstn,
  input  logic  rclk,
  input  logic  rrstn,
  input  data_t din,
  input  logic  din_valid,
  output logic  wready,
  input  logic  en,
  output data_t dout,
  output logic  dout_valid
);

  mem_wr_t mem_wr;
  mem_rd_t mem_rd;

  fifo_logic u_logic (
    .wclk       (wclk),
    .wrstn      (wrstn),
    .rclk       (rclk),
    .rrstn      (rrstn),
    .en         (en),
    .din_valid  (din_valid),
    .din        (din),
    .wready     (wready),
    .mem_wr     (mem_wr),
    .mem_rd     (mem_rd),
    .dout_valid (dout_valid)
  );

  fifo_mem u_mem (
    .wclk   (wclk),
    .rclk   (rclk),
    .mem_wr (mem_wr),
    .mem_rd (mem_rd),
    .rdata  (dout)
  );

endmodule

/* rtl/fifo_mem.sv */
/* Dual-clock storage with FIFO_DEPTH words and no reset.
   Write on wclk; the read data is registered on rclk and holds between reads. */
`timescale 1ns/1ps

module fifo_mem
  import fifo_pkg::*;
(
  input  logic    wclk,
  input  logic    rclk,
  input  mem_wr_t mem_wr,
  input  mem_rd_t mem_rd,
  output data_t   rdata
);

  data_t mem [FIFO_DEPTH];

  always_ff @(posedge wclk) begin
    if (mem_wr.en) begin
      mem[mem_wr.addr] <= mem_wr.data;
    end
  end

  // The pointer logic never reads an entry that is being written.
  always_ff @(posedge rclk) begin
    if (mem_rd.en) begin
      rdata <= mem[mem_rd.addr];
    end
  end

endmodule

/* rtl/gray_sync.sv */
/* Synchronizer chain for a Gray-coded pointer from a foreign clock domain.
   The input must change by at most one bit per source clock. */
`timescale 1ns/1ps

module gray_sync
  import fifo_pkg::*;
#(
  parameter int STAGES = SYNC_STAGES
) (
  input  logic clk,
  input  logic rstn,
  input  ptr_t d,
  output ptr_t q
);

  ptr_t sync_q [STAGES];

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= d;
      for (int i = 1; i < STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign q = sync_q[STAGES-1];

endmodule

/* tb/cdc_fifo_tb.sv */
/* Testbench for the dual-clock FIFO with a queue as reference model.
   Both clocks have a 100 ns period and wclk lags rclk by 37 ns, so edges never meet. */
`timescale 1ns/1ps

module cdc_fifo_tb
  import fifo_pkg::*;
;

  localparam logic [31:0] SEED = 32'he3cc91fd;
  // Reset, the directed tests and roughly 1000 cycles of random traffic, with wide margin.
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int RANDOM_WORDS   = 300;

  logic  wclk;
  logic  wrstn;
  logic  rclk;
  logic  rrstn;
  data_t din;
  logic  din_valid;
  logic  wready;
  logic  en;
  data_t dout;
  logic  dout_valid;

  data_t exp_q [$];
  string cur_test = "reset";
  int    wr_count = 0;
  int    rd_count = 0;
  int    checks_done = 0;
  int    value_errors = 0;
  int    other_errors = 0;
  int    cycle_count = 0;
  int    sent_count = 0;
  bit    writes_done = 1'b0;

  tb_clock_gen #(.PERIOD_NS(100.0), .PHASE_NS(0.0), .RST_CYCLES(16)) u_rclk_gen (
    .clk  (rclk),
    .rstn (rrstn)
  );

  tb_clock_gen #(.PERIOD_NS(100.0), .PHASE_NS(37.0), .RST_CYCLES(16)) u_wclk_gen (
    .clk  (wclk),
    .rstn (wrstn)
  );

  cdc_fifo UUT (
    .wclk       (wclk),
    .wrstn      (wrstn),
    .rclk       (rclk),
    .rrstn      (rrstn),
    .din        (din),
    .din_valid  (din_valid),
    .wready     (wready),
    .en         (en),
    .dout       (dout),
    .dout_valid (dout_valid)
  );

  // Expected next word, in the order the words were accepted.
  function automatic data_t next_expected();
    return exp_q.pop_front();
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks_done++;
    if (expected !== actual) begin
      value_errors++;
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_counts();
    $display("Checks run: %0d, value errors: %0d, other errors: %0d",
             checks_done, value_errors, other_errors);
  endtask

  // Called on a rising wclk edge; returns on the edge where the word is taken.
  task automatic write_word(input data_t value);
    din       <= value;
    din_valid <= 1'b1;
    @(posedge wclk);
    while (!wready) begin
      @(posedge wclk);
    end
  endtask

  task automatic wait_reads(input int target);
    while (rd_count < target) begin
      @(negedge rclk);
    end
  endtask

  // Every word the DUT accepts goes into the reference queue.
  always @(posedge wclk) begin
    if (wrstn && din_valid && wready) begin
      exp_q.push_back(din);
      wr_count++;
    end
  end

  always @(posedge rclk) begin
    if (rrstn && dout_valid) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("Error in test %s: dout_valid is high but no word is outstanding",
                 cur_test);
      end else begin
        check_value(cur_test, next_expected(), dout);
      end
      rd_count++;
    end
  end

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge rclk);
      cycle_count++;
    end
    $display("Timeout in test %s after %0d rclk cycles", cur_test, cycle_count);
    report_counts();
    $display("Errors found");
    $finish;
  end

  initial begin : stimulus
    int  wr_start;
    int  rd_start;
    bit  seen_full;

    din       = '0;
    din_valid = 1'b0;
    en        = 1'b0;
    void'($urandom(SEED));

    // Reset state, during and right after reset.
    @(posedge rclk);
    while (!rrstn) begin
      @(negedge rclk);
      check_value(cur_test, 0, dout_valid);
      check_value(cur_test, 1, wready);
    end
    while (!wrstn) begin
      @(posedge wclk);
    end
    repeat (3) begin
      @(negedge rclk);
      check_value(cur_test, 0, dout_valid);
      check_value(cur_test, 1, wready);
    end

    cur_test = "empty";
    @(posedge rclk);
    en <= 1'b1;
    @(negedge rclk);
    rd_start = rd_count;
    repeat (50) @(negedge rclk);
    check_value(cur_test, 0, rd_count - rd_start);

    cur_test = "burst";
    @(negedge wclk);
    wr_start = wr_count;
    rd_start = rd_count;
    @(posedge wclk);
    for (int i = 0; i < 10; i++) begin
      write_word(data_t'($urandom));
    end
    din_valid <= 1'b0;
    wait_reads(rd_start + 10);
    repeat (20) @(negedge rclk);
    check_value(cur_test, 10, wr_count - wr_start);
    check_value(cur_test, 10, rd_count - rd_start);

    cur_test = "full";
    @(posedge rclk);
    en <= 1'b0;
    repeat (4) @(posedge rclk);
    @(negedge wclk);
    wr_start  = wr_count;
    rd_start  = rd_count;
    seen_full = 1'b0;
    @(posedge wclk);
    din       <= data_t'($urandom);
    din_valid <= 1'b1;
    repeat (40) begin
      @(posedge wclk);
      if (seen_full) begin
        check_value(cur_test, 0, wready);
      end
      if (!wready) begin
        seen_full = 1'b1;
      end else begin
        din <= data_t'($urandom);
      end
    end
    din_valid <= 1'b0;
    @(negedge wclk);
    check_value(cur_test, FIFO_DEPTH, wr_count - wr_start);
    check_value(cur_test, 0, wready);
    check_value(cur_test, 0, rd_count - rd_start);
    @(posedge rclk);
    en <= 1'b1;
    wait_reads(rd_start + FIFO_DEPTH);
    repeat (SYNC_STAGES + 4) @(negedge wclk);
    check_value(cur_test, 1, wready);

    cur_test = "random";
    @(negedge wclk);
    wr_start = wr_count;
    rd_start = rd_count;
    @(posedge wclk);
    fork
      begin : writer
        while (sent_count < RANDOM_WORDS) begin
          if ($urandom_range(99) < 70) begin
            write_word(data_t'($urandom));
            sent_count++;
          end else begin
            din_valid <= 1'b0;
            @(posedge wclk);
          end
        end
        din_valid   <= 1'b0;
        writes_done = 1'b1;
      end
      begin : reader
        while (!writes_done) begin
          @(posedge rclk);
          en <= ($urandom_range(99) < 60);
        end
        @(posedge rclk);
        en <= 1'b1;
      end
    join
    wait_reads(rd_start + RANDOM_WORDS);
    repeat (20) @(negedge rclk);
    check_value(cur_test, RANDOM_WORDS, wr_count - wr_start);
    check_value(cur_test, RANDOM_WORDS, rd_count - rd_start);
    check_value(cur_test, 0, exp_q.size());

    report_counts();
    if (value_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* tb/tb_clock_gen.sv */
/* Clock and active-low reset for one clock domain of the testbench.
   Reset is released on a rising edge after RST_CYCLES cycles. */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS  = 100.0,
  parameter real PHASE_NS   = 0.0,
  parameter int  RST_CYCLES = 16
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk  = 1'b0;
    rstn = 1'b0;
    #(PHASE_NS);
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

  initial begin
    repeat (RST_CYCLES) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule
